// ==== build.f ====
+incdir+include
hdl/rs_pkg.sv
hdl/syndrome_accumulator.sv
hdl/syndrome_port.sv
hdl/rs_syndrome_unit.sv
testbench/rs_ref_model.sv
testbench/tb_rs_syndrome.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rs_syndrome
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_rs_syndrome.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module tb_rs_syndrome
	import rs_pkg::*, rs_ref_model::*;
();

	// four codewords plus read-out with margin
	localparam int CYCLE_LIMIT = 2 * (4 * 300 + 6 * 150);

	logic                      clock;
	logic                      reset;
	logic                      start;
	rx_byte_t                  rx;
	logic [`RS_READ_PORTS-1:0] send;
	syn_word_t                 resp [`RS_READ_PORTS];
	logic                      codeword_end;
	logic                      error_detected;

	logic [31:0]               seed = 32'd91310;
	codeword_t                 cw;
	syn_vec_t                  expected;
	int                        cycles = 0;
	int                        next_addr [`RS_READ_PORTS];
	int                        got_count [`RS_READ_PORTS];
	logic                      prev_reset;
	logic                      prev_start;
	logic                      prev_end;
	logic                      prev_err;
	logic [`RS_READ_PORTS-1:0] prev_send;

	rs_syndrome_unit rs_syndrome_unit_inst (
		.clock          (clock),
		.reset          (reset),
		.start          (start),
		.rx             (rx),
		.send           (send),
		.resp           (resp),
		.codeword_end   (codeword_end),
		.error_detected (error_detected)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input int want, input int got);
		abort_run($sformatf("FAIL at %0t: %s expected 0x%0h got 0x%0h", $time, name, want, got));
	endtask

	function automatic gf_elem_t rand_byte();
		seed = lcg_step(seed);
		return seed[23:16];
	endfunction

	// inputs seen at the previous edge and the run length guard
	always @(posedge clock)
	begin
		cycles     <= cycles + 1;
		prev_reset <= reset;
		prev_start <= start;
		prev_end   <= codeword_end;
		prev_err   <= error_detected;
		prev_send  <= send;
		if (cycles >= CYCLE_LIMIT)
			abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// once raised the flags hold until start
	assert property (@(posedge clock) disable iff (cycles < 2)
		(prev_reset && !prev_start && prev_end) |-> codeword_end)
	else
		report_mismatch("codeword_end", 1, int'($sampled(codeword_end)));

	assert property (@(posedge clock) disable iff (cycles < 2)
		(prev_reset && !prev_start && prev_end) |-> (error_detected == prev_err))
	else
		report_mismatch("error_detected", int'($sampled(prev_err)),
			int'($sampled(error_detected)));

	always @(posedge clock)
	begin
		logic exp_ready;

		if (cycles >= 2)
		begin
			if (!prev_reset || prev_start)
			begin
				assert (!codeword_end)
				else
					report_mismatch("codeword_end", 0, int'(codeword_end));
				assert (!error_detected)
				else
					report_mismatch("error_detected", 0, int'(error_detected));
			end
			for (int p = 0; p < `RS_READ_PORTS; p++)
			begin
				// ready follows the send of the previous edge once the codeword is in
				exp_ready = prev_reset && !prev_start && prev_end && prev_send[p];
				if (!prev_reset || prev_start)
					next_addr[p] = 0;
				assert (resp[p].ready == exp_ready)
				else
					report_mismatch($sformatf("resp[%0d].ready", p), int'(exp_ready),
						int'(resp[p].ready));
				if (resp[p].ready)
				begin
					assert (int'(resp[p].addr) == next_addr[p])
					else
						report_mismatch($sformatf("resp[%0d].addr", p), next_addr[p],
							int'(resp[p].addr));
					assert (resp[p].value == expected[resp[p].addr])
					else
						report_mismatch($sformatf("resp[%0d].value", p),
							int'(expected[resp[p].addr]), int'(resp[p].value));
					next_addr[p] = (next_addr[p] + 1) % `RS_NSYM;
					got_count[p] = got_count[p] + 1;
				end
			end
		end
	end

	task automatic pulse_start();
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic feed_codeword(input int extra);
		for (int d = `RS_N - 1; d >= 0; d--)
		begin
			@(negedge clock);
			assert (!codeword_end)
			else
				report_mismatch("codeword_end", 0, int'(codeword_end));
			assert (!error_detected)
			else
				report_mismatch("error_detected", 0, int'(error_detected));
			// an idle cycle now and then
			rx.strobe = 1'b0;
			if (rand_byte() < 8'd24)
				@(negedge clock);
			rx.strobe = 1'b1;
			rx.data   = cw[d];
		end
		@(negedge clock);
		rx.strobe = 1'b0;
		assert (codeword_end)
		else
			report_mismatch("codeword_end", 1, int'(codeword_end));
		assert (error_detected == (expected != '0))
		else
			report_mismatch("error_detected", int'(expected != '0), int'(error_detected));
		// strobes past the last byte must be ignored
		for (int k = 0; k < extra; k++)
		begin
			rx.strobe = 1'b1;
			rx.data   = rand_byte();
			@(negedge clock);
		end
		rx.strobe = 1'b0;
	endtask

	task automatic read_out(input logic [`RS_READ_PORTS-1:0] mask, input bit paced,
		input int target);
		int       first [`RS_READ_PORTS];
		logic     busy;
		logic     wanted;
		gf_elem_t coin;

		for (int p = 0; p < `RS_READ_PORTS; p++)
			first[p] = got_count[p];
		busy = 1'b1;
		while (busy)
		begin
			@(negedge clock);
			busy = 1'b0;
			for (int p = 0; p < `RS_READ_PORTS; p++)
			begin
				coin    = rand_byte();
				wanted  = mask[p] && (got_count[p] - first[p] < target);
				send[p] = wanted && (!paced || coin[0]);
				busy    = busy || wanted;
			end
		end
		// responses still in flight
		repeat (2) @(negedge clock);
	endtask

	initial
	begin
		codeword_t msg;
		int        pos;

		reset    = 1'b0;
		start    = 1'b0;
		rx       = '0;
		send     = '0;
		cw       = '0;
		expected = '0;
		for (int p = 0; p < `RS_READ_PORTS; p++)
		begin
			next_addr[p] = 0;
			got_count[p] = 0;
		end
		repeat (3) @(negedge clock);
		reset = 1'b1;

		// valid codeword where every port reads zeros
		for (int d = 0; d < `RS_N; d++)
			msg[d] = rand_byte();
		cw       = encode_message(msg);
		expected = expected_syndromes(cw);
		feed_codeword(0);
		read_out('1, 1'b0, `RS_NSYM);

		// one corrupted byte while port 0 waits on send through the whole codeword
		pulse_start();
		pos      = int'(rand_byte()) % `RS_N;
		cw[pos]  = cw[pos] ^ (rand_byte() | 8'h01);
		expected = expected_syndromes(cw);
		send[0]  = 1'b1;
		feed_codeword(0);
		assert (!resp[0].ready)
		else
			report_mismatch("resp[0].ready", 0, int'(resp[0].ready));
		@(negedge clock);
		assert (resp[0].ready)
		else
			report_mismatch("resp[0].ready", 1, int'(resp[0].ready));
		read_out({{(`RS_READ_PORTS - 1){1'b0}}, 1'b1}, 1'b0, `RS_NSYM);

		// random bytes with trailing strobes and a paced read-out before a second pass
		pulse_start();
		for (int d = 0; d < `RS_N; d++)
			cw[d] = rand_byte();
		expected = expected_syndromes(cw);
		feed_codeword(20);
		read_out('1, 1'b1, `RS_NSYM + 8);
		read_out('1, 1'b0, `RS_NSYM);

		// another valid codeword with nothing carried over
		pulse_start();
		for (int d = 0; d < `RS_N; d++)
			msg[d] = rand_byte();
		cw       = encode_message(msg);
		expected = expected_syndromes(cw);
		feed_codeword(5);
		read_out('1, 1'b1, `RS_NSYM);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/rs_ref_model.sv ====
`default_nettype none

`include "rs_cfg.svh"

package rs_ref_model;
	import rs_pkg::*;

	// one codeword, entry d is the coefficient of x^d, sent from the top down
	typedef gf_elem_t [`RS_N-1:0] codeword_t;

	// full carry-less product, then reduced from the top by x^8 + RS_POLY
	function automatic gf_elem_t field_product(input gf_elem_t a, input gf_elem_t b);
		logic [14:0] wide;

		wide = '0;
		for (int i = 0; i < 8; i++)
		begin
			if (a[i])
				wide = wide ^ (15'(b) << i);
		end
		for (int i = 14; i >= 8; i--)
		begin
			if (wide[i])
				wide = wide ^ (15'({1'b1, `RS_POLY}) << (i - 8));
		end
		return wide[7:0];
	endfunction

	// S(j) = r(alpha^j) as a plain power sum
	function automatic syn_vec_t expected_syndromes(input codeword_t cw);
		syn_vec_t syn;
		gf_elem_t root;
		gf_elem_t term;

		syn  = '0;
		root = 8'h01;
		for (int j = 1; j <= `RS_NSYM; j++)
		begin
			root = field_product(root, 8'h02);
			term = 8'h01;
			for (int d = 0; d < `RS_N; d++)
			begin
				syn[j - 1] = syn[j - 1] ^ field_product(cw[d], term);
				term       = field_product(term, root);
			end
		end
		return syn;
	endfunction

	// c(x) = m(x) g(x) with g(x) = (x + alpha) ... (x + alpha^32)
	function automatic codeword_t encode_message(input codeword_t msg);
		gf_elem_t  gen [`RS_NSYM + 1];
		gf_elem_t  root;
		codeword_t cw;

		for (int k = 0; k <= `RS_NSYM; k++)
			gen[k] = 8'h00;
		gen[0] = 8'h01;
		root   = 8'h01;
		for (int i = 1; i <= `RS_NSYM; i++)
		begin
			root = field_product(root, 8'h02);
			for (int k = i; k >= 1; k--)
				gen[k] = gen[k - 1] ^ field_product(gen[k], root);
			gen[0] = field_product(gen[0], root);
		end
		// message sits in degrees 0 .. RS_N - RS_NSYM - 1
		cw = '0;
		for (int i = 0; i < `RS_N - `RS_NSYM; i++)
		begin
			for (int k = 0; k <= `RS_NSYM; k++)
				cw[i + k] = cw[i + k] ^ field_product(msg[i], gen[k]);
		end
		return cw;
	endfunction

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/rs_syndrome_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module rs_syndrome_unit
	import rs_pkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      start,
	input  rx_byte_t                  rx,
	input  logic [`RS_READ_PORTS-1:0] send,
	output syn_word_t                 resp [`RS_READ_PORTS],
	output logic                      codeword_end,
	output logic                      error_detected
);

	// shared by every read port
	syn_vec_t syndromes;

	syndrome_accumulator accumulator_inst (
		.clock          (clock),
		.reset          (reset),
		.start          (start),
		.rx             (rx),
		.syndromes      (syndromes),
		.codeword_end   (codeword_end),
		.error_detected (error_detected)
	);

	// each consumer walks the syndromes at its own pace
	for (genvar p = 0; p < `RS_READ_PORTS; p++)
	begin : g_port
		syndrome_port port_inst (
			.clock        (clock),
			.reset        (reset),
			.start        (start),
			.codeword_end (codeword_end),
			.send         (send[p]),
			.syndromes    (syndromes),
			.resp         (resp[p])
		);
	end

endmodule

`default_nettype wire

// ==== hdl/syndrome_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module syndrome_port
	import rs_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      start,
	input  logic      codeword_end,
	input  logic      send,
	input  syn_vec_t  syndromes,
	output syn_word_t resp
);

	localparam syn_addr_t LAST_ADDR = syn_addr_t'(`RS_NSYM - 1);

	syn_addr_t count;
	syn_addr_t count_next;
	logic      honour;
	gf_elem_t  coef;
	logic      ready_q;
	syn_addr_t addr_q;
	gf_elem_t  value_q;

	// a request only counts once the syndromes are final
	assign honour = codeword_end && send;

	// wrap after the last coefficient
	assign count_next = (count == LAST_ADDR) ? '0 : count + 1'b1;

	// address a returns S(a+1), which sits in entry a
	assign coef = syndromes[count];

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			count   <= '0;
			ready_q <= 1'b0;
		end
		else if (start)
		begin
			count   <= '0;
			ready_q <= 1'b0;
		end
		else
		begin
			// ready follows the honoured send, count holds while paused
			ready_q <= honour;
			if (honour)
				count <= count_next;
		end
	end

	always_ff @(posedge clock)
	begin
		if (honour)
		begin
			addr_q  <= count;
			value_q <= coef;
		end
	end

	assign resp.ready = ready_q;
	assign resp.addr  = addr_q;
	assign resp.value = value_q;

endmodule

`default_nettype wire

// ==== hdl/syndrome_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rs_cfg.svh"

module syndrome_accumulator
	import rs_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     start,
	input  rx_byte_t rx,
	output syn_vec_t syndromes,
	output logic     codeword_end,
	output logic     error_detected
);

	// counter values as plain integers, sliced to the counter width below
	localparam int CODE_LEN   = `RS_N;
	localparam int LAST_INDEX = `RS_N - 1;

	logic [`RS_CNT_W-1:0] byte_count;
	logic                 full;
	logic                 accept;
	logic                 last_byte;
	logic                 any_nonzero;
	syn_vec_t             syn_next;
	gf_elem_t             syn_q [`RS_NSYM];

	// a full codeword has been taken, later strobes are dropped
	assign full = (byte_count == CODE_LEN[`RS_CNT_W-1:0]);

	assign accept = rx.strobe && !full;

	// this strobe completes the codeword
	assign last_byte = accept && (byte_count == LAST_INDEX[`RS_CNT_W-1:0]);

	// zero test on the values the last byte produces, so the flag lands with it
	assign any_nonzero = |syn_next;

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			byte_count <= '0;
		end
		else if (start)
		begin
			byte_count <= '0;
		end
		else if (accept)
		begin
			byte_count <= byte_count + 1'b1;
		end
	end

	// one Horner cell per syndrome: S <- S * alpha^(i+1) + r
	for (genvar i = 0; i < `RS_NSYM; i++)
	begin : g_cell
		localparam gf_elem_t ROOT = gf_alpha_pow(i + 1);

		assign syn_next[i] = gf_mul(syn_q[i], ROOT) ^ rx.data;

		// cleared for every new codeword, so it needs start and reset alike
		always_ff @(posedge clock)
		begin
			if (!reset)
			begin
				syn_q[i] <= '0;
			end
			else if (start)
			begin
				syn_q[i] <= '0;
			end
			else if (accept)
			begin
				syn_q[i] <= syn_next[i];
			end
		end

		assign syndromes[i] = syn_q[i];
	end

	// both flags rise with the last byte and hold until start
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			codeword_end   <= 1'b0;
			error_detected <= 1'b0;
		end
		else if (start)
		begin
			codeword_end   <= 1'b0;
			error_detected <= 1'b0;
		end
		else if (last_byte)
		begin
			codeword_end   <= 1'b1;
			error_detected <= any_nonzero;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rs_pkg.sv ====
`default_nettype none

`include "rs_cfg.svh"

package rs_pkg;

	// one symbol of GF(2^8)
	typedef logic [7:0] gf_elem_t;

	// index into the syndrome set, address a holds S(a+1)
	typedef logic [`RS_ADDR_W-1:0] syn_addr_t;

	// the whole syndrome set, entry i is S(i+1)
	typedef gf_elem_t [`RS_NSYM-1:0] syn_vec_t;

	// one received byte with its strobe
	typedef struct packed {
		logic     strobe;
		gf_elem_t data;
	} rx_byte_t;

	// one read-out response
	typedef struct packed {
		logic      ready;
		syn_addr_t addr;
		gf_elem_t  value;
	} syn_word_t;

	// primitive element of the field
	localparam gf_elem_t GF_ALPHA = 8'h02;

	// multiplicative group order
	localparam int unsigned GF_ORDER = 255;

	// shift and add product, reduced by the field polynomial on every shift
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;

		acc = '0;
		sh  = a;
		for (int k = 0; k < 8; k++)
		begin
			if (b[k])
				acc = acc ^ sh;
			if (sh[7])
				sh = {sh[6:0], 1'b0} ^ `RS_POLY;
			else
				sh = {sh[6:0], 1'b0};
		end
		return acc;
	endfunction

	// alpha^power, only called with constants so it folds away
	function automatic gf_elem_t gf_alpha_pow(input int unsigned power);
		gf_elem_t    elem;
		int unsigned steps;

		elem  = 8'h01;
		steps = power % GF_ORDER;
		for (int unsigned k = 0; k < steps; k++)
		begin
			elem = gf_mul(elem, GF_ALPHA);
		end
		return elem;
	endfunction

endpackage

`default_nettype wire

// ==== include/rs_cfg.svh ====
`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// RS(255,223) over GF(2^8)

// received bytes per codeword
`define RS_N 255

// syndromes S(1) .. S(32), one per root alpha^1 .. alpha^32
`define RS_NSYM 32

// x^8 + x^4 + x^3 + x^2 + 1 without the x^8 term
`define RS_POLY 8'h1D

// independent read-out consumers
`define RS_READ_PORTS 4

// coefficient address, wide enough for RS_NSYM entries
`define RS_ADDR_W 5

// byte counter, must hold RS_N
`define RS_CNT_W 8

`endif
